//--- hdl/cpu_reg_pkg.sv
// register codes, register-bank widths and full register types
package cpu_reg_pkg;

    localparam int REG_CODE_W = 8;  // byte code in the register map
    localparam int FULL_W     = 32; // XWA through XSP
    localparam int N_FULL     = 8;
    localparam int IDX_W      = $clog2(N_FULL);

    typedef logic [REG_CODE_W-1:0] reg_code_t;
    typedef logic [FULL_W-1:0]     full_reg_t;
    typedef logic [IDX_W-1:0]      reg_idx_t;  // full register number
    typedef logic [1:0]            byte_sel_t; // byte inside a full register

    // 40h sits outside the full-register block and reads as zero
    localparam reg_code_t NULL_REG  = 8'h40;

    // full registers start at E0h, four codes apart
    // E0 XWA, E4 XBC, E8 XDE, EC XHL
    // F0 XIX, F4 XIY, F8 XIZ, FC XSP
    localparam reg_code_t FULL_BASE = 8'hE0;

endpackage

//--- hdl/idx_mode_pkg.sv
// addressing-mode codes, step codes, byte counts and address types
package idx_mode_pkg;

    localparam int ADDR_W = 24; // memory address width

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [4:0]        mode_t;  // {op[6], op[3:0]}
    typedef logic [1:0]        step_t;
    typedef logic [2:0]        fetch_t; // bytes consumed per cycle

    // modes with bit 4 clear are register indirect, with op[3] adding a d8
    localparam mode_t MODE_ABS8    = 5'h10;
    localparam mode_t MODE_ABS16   = 5'h11;
    localparam mode_t MODE_ABS24   = 5'h12;
    localparam mode_t MODE_R32     = 5'h13;
    localparam mode_t MODE_PREDEC  = 5'h14;
    localparam mode_t MODE_POSTINC = 5'h15;

    localparam step_t STEP_1 = 2'd0;
    localparam step_t STEP_2 = 2'd1;
    localparam step_t STEP_4 = 2'd2; // code 3 is reserved

    localparam fetch_t FETCH_NONE = 3'd0;
    localparam fetch_t FETCH_ONE  = 3'd1;
    localparam fetch_t FETCH_TWO  = 3'd2;
    localparam fetch_t FETCH_FOUR = 3'd4;

endpackage

//--- hdl/reg_port_if.sv
// index and offset register reads plus step commands, unit to bank
`timescale 1ns/10ps

interface reg_port_if;

    cpu_reg_pkg::reg_code_t rd_sel;   // index register code
    cpu_reg_pkg::full_reg_t rd_data;
    cpu_reg_pkg::reg_code_t aux_sel;  // offset register code
    logic [15:0]            aux_data; // 16 bits from byte aux_sel[1:0]
    idx_mode_pkg::step_t    step;
    logic                   inc;      // step the rd_sel register up
    logic                   dec;      // step the rd_sel register down

    modport unit (
        output rd_sel, aux_sel, step, inc, dec,
        input  rd_data, aux_data
    );

    modport bank (
        input  rd_sel, aux_sel, step, inc, dec,
        output rd_data, aux_data
    );

endinterface

//--- hdl/idx_addr_unit.sv
// two-phase memory addressing-field decoder and effective-address adder
`timescale 1ns/10ps

module idx_addr_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [31:0]             op,
    input  logic                    idx_en,
    output idx_mode_pkg::fetch_t    fetched,
    output logic                    idx_ok,
    output idx_mode_pkg::mem_addr_t idx_addr,
    reg_port_if.unit                rp
);

    idx_mode_pkg::mode_t     op_mode;
    idx_mode_pkg::mode_t     mode_q, nx_mode;
    logic                    phase_q, nx_phase;
    logic                    pre_ok, nx_pre_ok;
    logic                    ridx_q, nx_ridx;   // offset comes from a register
    logic                    wide_q, nx_wide;   // 16-bit offset register
    logic                    post_q, nx_post;   // increment pending
    logic                    dec_now;
    idx_mode_pkg::step_t     step_q, nx_step;
    cpu_reg_pkg::reg_code_t  sel_q, nx_sel;
    cpu_reg_pkg::reg_code_t  aux_q, nx_aux;
    idx_mode_pkg::mem_addr_t offset_q, nx_offset;
    idx_mode_pkg::mem_addr_t aux_ext;
    idx_mode_pkg::mem_addr_t nx_addr;

    assign op_mode = {op[6], op[3:0]};

    // codes go out ahead of the flops so the bank steps in the decode cycle
    assign rp.rd_sel  = nx_sel;
    assign rp.aux_sel = nx_aux;
    assign rp.step    = nx_step;
    assign rp.inc     = post_q;
    assign rp.dec     = dec_now;

    assign aux_ext = wide_q ? {{8{rp.aux_data[15]}}, rp.aux_data}
                            : {{16{rp.aux_data[7]}}, rp.aux_data[7:0]};

    assign nx_addr = (idx_en && !idx_ok)
                   ? rp.rd_data[23:0] + (ridx_q ? aux_ext : offset_q)
                   : idx_addr;

    always_comb begin
        fetched   = idx_mode_pkg::FETCH_NONE;
        nx_mode   = mode_q;
        nx_phase  = 1'b0;
        nx_pre_ok = pre_ok & idx_en; // cleared once idx_en drops
        nx_ridx   = ridx_q;
        nx_wide   = wide_q;
        nx_post   = 1'b0;
        dec_now   = 1'b0;
        nx_step   = step_q;
        nx_sel    = sel_q;
        nx_aux    = aux_q;
        nx_offset = offset_q;
        if (idx_en && !pre_ok) begin
            if (!phase_q) begin
                nx_mode = op_mode;
                nx_ridx = 1'b0;
                casez (op_mode)
                    5'b0_????: begin // (r32) and (r32+d8)
                        nx_sel    = cpu_reg_pkg::FULL_BASE | {3'b000, op[2:0], 2'b00};
                        nx_offset = op[3] ? {{16{op[15]}}, op[15:8]} : '0;
                        fetched   = op[3] ? idx_mode_pkg::FETCH_TWO
                                          : idx_mode_pkg::FETCH_ONE;
                        nx_pre_ok = 1'b1;
                    end
                    idx_mode_pkg::MODE_ABS8,
                    idx_mode_pkg::MODE_ABS16,
                    idx_mode_pkg::MODE_ABS24: begin
                        nx_sel    = cpu_reg_pkg::NULL_REG;
                        nx_offset = {16'd0, op[15:8]}; // low byte first
                        fetched   = idx_mode_pkg::FETCH_TWO;
                        if (op_mode == idx_mode_pkg::MODE_ABS8) begin
                            nx_pre_ok = 1'b1;
                        end else begin
                            nx_phase = 1'b1;
                        end
                    end
                    idx_mode_pkg::MODE_R32: begin
                        nx_sel    = {op[15:10], 2'b00};
                        nx_offset = '0;
                        fetched   = idx_mode_pkg::FETCH_TWO;
                        if (!op[8]) begin
                            nx_pre_ok = 1'b1; // plain (r32)
                        end else if (!op[9]) begin
                            nx_phase = 1'b1;  // d16 follows
                        end else begin
                            nx_phase = 1'b1;  // register bytes read unshifted
                            nx_ridx  = 1'b1;
                            nx_wide  = op[10];
                            fetched  = idx_mode_pkg::FETCH_NONE;
                        end
                    end
                    idx_mode_pkg::MODE_PREDEC,
                    idx_mode_pkg::MODE_POSTINC: begin
                        nx_sel    = {op[15:10], 2'b00};
                        nx_offset = '0;
                        nx_step   = op[9:8];
                        fetched   = idx_mode_pkg::FETCH_TWO;
                        dec_now   = (op_mode == idx_mode_pkg::MODE_PREDEC);
                        nx_post   = (op_mode == idx_mode_pkg::MODE_POSTINC);
                        nx_pre_ok = 1'b1;
                    end
                    default: ;
                endcase
            end else begin
                nx_pre_ok = 1'b1;
                case (mode_q)
                    idx_mode_pkg::MODE_ABS16: begin
                        nx_offset[23:8] = {8'd0, op[7:0]};
                        fetched         = idx_mode_pkg::FETCH_ONE;
                    end
                    idx_mode_pkg::MODE_ABS24: begin
                        nx_offset[23:8] = op[15:0];
                        fetched         = idx_mode_pkg::FETCH_TWO;
                    end
                    idx_mode_pkg::MODE_R32: begin
                        if (ridx_q) begin
                            nx_sel  = op[23:16]; // base register
                            nx_aux  = op[31:24]; // offset register
                            fetched = idx_mode_pkg::FETCH_FOUR;
                        end else begin
                            nx_offset = {{8{op[15]}}, op[15:0]};
                            fetched   = idx_mode_pkg::FETCH_TWO;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q  <= '0;
            phase_q <= 1'b0;
            pre_ok  <= 1'b0;
            idx_ok  <= 1'b0;
            ridx_q  <= 1'b0;
            wide_q  <= 1'b0;
            post_q  <= 1'b0;
            step_q  <= idx_mode_pkg::STEP_1;
            sel_q   <= cpu_reg_pkg::NULL_REG;
            aux_q   <= cpu_reg_pkg::NULL_REG;
        end else if (cen) begin
            mode_q  <= nx_mode;
            phase_q <= nx_phase;
            pre_ok  <= nx_pre_ok;
            idx_ok  <= pre_ok;   // one edge behind pre_ok
            ridx_q  <= nx_ridx;
            wide_q  <= nx_wide;
            post_q  <= nx_post;  // inc lands after the address is taken
            step_q  <= nx_step;
            sel_q   <= nx_sel;
            aux_q   <= nx_aux;
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            offset_q <= nx_offset;
            idx_addr <= nx_addr;
        end
    end

endmodule

//--- hdl/idx_reg_bank.sv
// eight full registers with index and offset read ports, stepping and load
`timescale 1ns/10ps

module idx_reg_bank (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    input  logic                   ld_en,
    input  cpu_reg_pkg::reg_idx_t  ld_sel,
    input  cpu_reg_pkg::full_reg_t ld_data,
    reg_port_if.bank               rp
);

    cpu_reg_pkg::full_reg_t  regs [cpu_reg_pkg::N_FULL];
    logic                    rd_hit, aux_hit;
    cpu_reg_pkg::reg_idx_t   rd_idx, aux_idx;
    cpu_reg_pkg::byte_sel_t  rd_byte, aux_byte;
    cpu_reg_pkg::full_reg_t  aux_word;
    cpu_reg_pkg::full_reg_t  step_amt;

    // code layout 111 rrr bb, anything else reads zero
    assign rd_hit   = (rp.rd_sel[7:5] == cpu_reg_pkg::FULL_BASE[7:5]);
    assign rd_idx   = rp.rd_sel[4:2];
    assign rd_byte  = rp.rd_sel[1:0];
    assign aux_hit  = (rp.aux_sel[7:5] == cpu_reg_pkg::FULL_BASE[7:5]);
    assign aux_idx  = rp.aux_sel[4:2];
    assign aux_byte = rp.aux_sel[1:0];

    assign rp.rd_data = rd_hit ? (regs[rd_idx] >> {rd_byte, 3'b000}) : '0;

    // upper bytes shift in as zero past byte 3
    assign aux_word    = aux_hit ? (regs[aux_idx] >> {aux_byte, 3'b000}) : '0;
    assign rp.aux_data = aux_word[15:0];

    always_comb begin
        case (rp.step)
            idx_mode_pkg::STEP_1: step_amt = 32'd1;
            idx_mode_pkg::STEP_2: step_amt = 32'd2;
            idx_mode_pkg::STEP_4: step_amt = 32'd4;
            default:              step_amt = '0; // reserved, no change
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cpu_reg_pkg::N_FULL; i++) begin
                regs[i] <= '0;
            end
        end else if (cen) begin
            if (ld_en) begin
                regs[ld_sel] <= ld_data; // preset wins over a step
            end else if (rd_hit && rp.inc) begin
                regs[rd_idx] <= regs[rd_idx] + step_amt;
            end else if (rd_hit && rp.dec) begin
                regs[rd_idx] <= regs[rd_idx] - step_amt;
            end
        end
    end

endmodule

//--- hdl/idx_addr_top.sv
// indexed-address stage top with address unit and full register bank
`timescale 1ns/10ps

module idx_addr_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic [31:0]             op,
    input  logic                    idx_en,
    input  logic                    ld_en,
    input  logic [2:0]              ld_sel,
    input  logic [31:0]             ld_data,
    output idx_mode_pkg::fetch_t    fetched,
    output logic                    idx_ok,
    output idx_mode_pkg::mem_addr_t idx_addr
);

    reg_port_if rp ();

    idx_addr_unit i_idx_addr_unit (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .op       (op),
        .idx_en   (idx_en),
        .fetched  (fetched),
        .idx_ok   (idx_ok),
        .idx_addr (idx_addr),
        .rp       (rp.unit)
    );

    idx_reg_bank i_idx_reg_bank (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .ld_en   (ld_en),
        .ld_sel  (ld_sel),
        .ld_data (ld_data),
        .rp      (rp.bank)
    );

endmodule

//--- verification/idx_addr_tb.sv
// testbench with clock, reset, random ops, register model, reference function and checks
`timescale 1ns/10ps

module idx_addr_tb;

    localparam int N_REQ   = 8 + 16 + 12 + 16 + 18 + 200; // requests in all test groups
    localparam int TIMEOUT = 12 * N_REQ + 20;

    logic                      clk = 1'b0;
    logic                      rst, cen, idx_en, ld_en;
    logic [31:0]               op, ld_data;
    logic [2:0]                ld_sel;
    idx_mode_pkg::fetch_t      fetched;
    logic                      idx_ok;
    idx_mode_pkg::mem_addr_t   idx_addr;

    cpu_reg_pkg::full_reg_t    model [8];        // copy of XWA..XSP
    logic [31:0]               lfsr_state = 32'd1931;
    idx_mode_pkg::mem_addr_t   exp_addr_q [$];
    idx_mode_pkg::fetch_t      exp_bytes_q [$];
    int                        exp_lat_q [$];
    int                        cycle_cnt = 0;

    // checker state from the previous negedge
    logic                      cen_prev = 1'b1, en_prev = 1'b0, ok_prev = 1'b0;
    idx_mode_pkg::fetch_t      fetch_prev = '0;
    idx_mode_pkg::mem_addr_t   addr_prev = '0;
    idx_mode_pkg::fetch_t      byte_cnt = '0;
    int                        lat_cnt = 0;

    idx_addr_top i_idx_addr_top (
        .clk (clk), .rst (rst), .cen (cen), .op (op), .idx_en (idx_en),
        .ld_en (ld_en), .ld_sel (ld_sel), .ld_data (ld_data),
        .fetched (fetched), .idx_ok (idx_ok), .idx_addr (idx_addr)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic pick_cen(input logic rnd);
        return rnd ? (take_bits(2) != 32'd0) : 1'b1; // low about one cycle in four
    endfunction

    // E0h..FFh pick a byte lane of a full register and other codes read zero
    function automatic cpu_reg_pkg::full_reg_t read_code(input cpu_reg_pkg::reg_code_t code);
        if (code[7:5] != 3'b111) return '0;
        return model[code[4:2]] >> (8 * code[1:0]);
    endfunction

    function automatic cpu_reg_pkg::full_reg_t step_amount(input idx_mode_pkg::step_t s);
        case (s)
            2'd0: return 32'd1;
            2'd1: return 32'd2;
            2'd2: return 32'd4;
            default: return 32'd0;
        endcase
    endfunction

    // expected address, byte total, latency and register update for one op
    function automatic idx_mode_pkg::mem_addr_t ref_decode(
        input logic [31:0] w, output idx_mode_pkg::fetch_t nbytes, output int lat,
        output logic chg, output int ci, output cpu_reg_pkg::full_reg_t cv);
        logic [7:0]              b0, b1, b2, b3;
        cpu_reg_pkg::full_reg_t  base, auxw;
        idx_mode_pkg::mem_addr_t ea;
        {b3, b2, b1, b0} = w;
        nbytes = 3'd2;
        lat = 2;
        chg = 1'b0;
        ci = 0;
        cv = '0;
        base = read_code({b1[7:2], 2'b00});
        ea = base[23:0];
        if (!b0[6]) begin
            base = model[b0[2:0]];
            ea = base[23:0] + (b0[3] ? {{16{b1[7]}}, b1} : 24'd0);
            nbytes = b0[3] ? 3'd2 : 3'd1;
        end else begin
            case (b0[3:0])
                4'h0: ea = {16'd0, b1};
                4'h1: ea = {8'd0, b2, b1};
                4'h2: ea = {b3, b2, b1};
                4'h3: begin
                    if (b1[1:0] == 2'b01) begin
                        ea = base[23:0] + {{8{b3[7]}}, b3, b2}; // d16
                    end else if (b1[1:0] == 2'b11) begin
                        base = read_code(b2);
                        auxw = read_code(b3);
                        ea = base[23:0] + (b1[2] ? {{8{auxw[15]}}, auxw[15:0]}
                                                 : {{16{auxw[7]}}, auxw[7:0]});
                    end
                end
                default: begin // pre-decrement and post-increment
                    if (b1[7:5] == 3'b111) begin
                        chg = 1'b1;
                        ci = int'(b1[4:2]);
                        cv = b0[0] ? model[ci] + step_amount(b1[1:0])
                                   : model[ci] - step_amount(b1[1:0]);
                        ea = b0[0] ? model[ci][23:0] : cv[23:0];
                    end
                end
            endcase
            if (b0[3:0] == 4'h1) nbytes = 3'd3;
            if (b0[3:0] == 4'h2 || (b0[3:0] == 4'h3 && b1[0])) nbytes = 3'd4;
            if (nbytes > 3'd2) lat = 3;
        end
        return ea;
    endfunction

    // forms 0..9 are (r), (r+d8), abs8/16/24, r32, r32+d16, r32+reg, -(r) and (r)+
    function automatic logic [31:0] gen_op(input int form);
        logic [31:0] w;
        logic [2:0]  r;
        logic [1:0]  st;
        w = take_bits(32);
        r = 3'(take_bits(3));
        st = 2'(take_bits(2));
        st = (st == 2'd3) ? 2'd2 : st; // code 3 is reserved
        case (form)
            0, 1: w[7:0] = {w[7], 1'b0, w[5:4], 1'(form), r};
            2, 3, 4: w[7:0] = {w[7], 1'b1, w[5:4], 4'(form - 2)};
            5, 6, 7: begin
                w[7:0] = {w[7], 1'b1, w[5:4], 4'h3};
                w[15:8] = {3'b111, r, (form == 5) ? w[9] : form[0], 1'(form != 5)};
                w[23:21] = 3'b111;
                w[31:29] = 3'b111;
            end
            default: begin
                w[7:0] = {w[7], 1'b1, w[5:4], 4'(form - 4)};
                w[15:8] = {3'b111, r, st};
            end
        endcase
        return w;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_addr(input idx_mode_pkg::mem_addr_t got,
                              input idx_mode_pkg::mem_addr_t exp);
        if (got !== exp) report_error($sformatf("idx_addr %06h, expected %06h", got, exp));
    endtask

    task automatic check_fetch(input idx_mode_pkg::fetch_t got,
                               input idx_mode_pkg::fetch_t exp);
        if (got !== exp) report_error($sformatf("fetched %0d bytes, expected %0d", got, exp));
    endtask

    task automatic check_reg(input cpu_reg_pkg::full_reg_t got,
                             input cpu_reg_pkg::full_reg_t exp);
        if (got !== exp) report_error($sformatf("register %08h, expected %08h", got, exp));
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) report_error($sformatf("idx_ok after %0d cycles, expected %0d", got, exp));
    endtask

    task automatic load_reg(input logic [2:0] r, input cpu_reg_pkg::full_reg_t v);
        @(posedge clk);
        ld_en <= 1'b1;
        ld_sel <= r;
        ld_data <= v;
        @(posedge clk);
        ld_en <= 1'b0;
        model[r] = v;
    endtask

    // sequencer holds idx_en until idx_ok and shifts op by the bytes taken
    task automatic run_request(input logic [31:0] w, input logic rnd,
                               output idx_mode_pkg::mem_addr_t got);
        idx_mode_pkg::fetch_t    nb, f;
        int                      lat, ci, quiet;
        logic                    chg, c, ok;
        cpu_reg_pkg::full_reg_t  cv;
        exp_addr_q.push_back(ref_decode(w, nb, lat, chg, ci, cv));
        exp_bytes_q.push_back(nb);
        exp_lat_q.push_back(lat);
        if (chg) model[ci] = cv;
        @(posedge clk);
        op <= w;
        idx_en <= 1'b1;
        cen <= pick_cen(rnd);
        ok = 1'b0;
        while (!ok) begin
            @(negedge clk);
            f = fetched;
            c = cen;
            ok = idx_ok;
            got = idx_addr;
            @(posedge clk);
            if (c && !ok) op <= op >> (8 * f);
            cen <= pick_cen(rnd);
        end
        idx_en <= 1'b0;
        quiet = 0;
        while (quiet < 2) begin // two enabled edges with idx_en low
            @(negedge clk);
            c = cen;
            @(posedge clk);
            if (c) quiet++;
            cen <= pick_cen(rnd);
        end
    endtask

    // reads a full register as its low 24 bits plus its upper 24 through byte lane 1
    task automatic read_reg(input logic [2:0] r, output cpu_reg_pkg::full_reg_t v);
        idx_mode_pkg::mem_addr_t lo, hi;
        run_request({29'd0, r}, 1'b0, lo);
        run_request({8'h40, 3'b111, r, 2'b01, 8'h03, 8'h43}, 1'b0, hi);
        v = {hi, lo[7:0]};
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (!cen_prev) begin // nothing moves on a disabled edge
                check_addr(idx_addr, addr_prev);
                if (idx_ok !== ok_prev) report_error("idx_ok changed on an edge with cen low");
                if (idx_en && en_prev) check_fetch(fetched, fetch_prev);
            end
            if (cen_prev && en_prev) lat_cnt++;
            if (idx_en && cen) byte_cnt += fetched;
            if (idx_ok && !ok_prev) begin
                if (exp_addr_q.size() == 0) report_error("idx_ok rose with no request open");
                check_addr(idx_addr, exp_addr_q.pop_front());
                check_fetch(byte_cnt, exp_bytes_q.pop_front());
                check_latency(lat_cnt, exp_lat_q.pop_front());
            end
            if (!idx_en) begin
                lat_cnt = 0;
                byte_cnt = '0;
            end
        end
        cen_prev = cen;
        en_prev = idx_en;
        ok_prev = idx_ok;
        fetch_prev = fetched;
        addr_prev = idx_addr;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout: the requests did not finish within %0d cycles", TIMEOUT);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    initial begin
        idx_mode_pkg::mem_addr_t a;
        cpu_reg_pkg::full_reg_t  v;
        rst = 1'b1;
        cen = 1'b1;
        op = '0;
        idx_en = 1'b0;
        ld_en = 1'b0;
        ld_sel = '0;
        ld_data = '0;
        for (int i = 0; i < 8; i++) model[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (idx_ok !== 1'b0) report_error("idx_ok is high after reset");
        for (int r = 0; r < 8; r++) begin
            run_request({29'd0, 3'(r)}, 1'b0, a);
            check_addr(a, 24'd0); // registers clear after reset
        end
        for (int r = 0; r < 8; r++) load_reg(3'(r), take_bits(32));
        for (int i = 0; i < 16; i++) run_request(gen_op(i / 8), 1'b0, a);
        for (int i = 0; i < 12; i++) run_request(gen_op(2 + i % 3), 1'b0, a);
        for (int i = 0; i < 16; i++) run_request(gen_op(5 + i % 3), 1'b0, a);
        for (int s = 0; s < 3; s++) begin
            for (int m = 0; m < 2; m++) begin
                run_request({16'd0, 3'b111, 3'(2 * s + m), 2'(s), 7'h22, 1'(m)}, 1'b0, a);
                read_reg(3'(2 * s + m), v);
                check_reg(v, model[2 * s + m]);
            end
        end
        for (int i = 0; i < 200; i++) run_request(gen_op(int'(take_bits(4)) % 10), 1'b1, a);
        @(negedge clk);
        if (exp_addr_q.size() != 0) begin
            report_error("requests left without idx_ok");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- filelist.f
hdl/cpu_reg_pkg.sv
hdl/idx_mode_pkg.sv
hdl/reg_port_if.sv
hdl/idx_addr_unit.sv
hdl/idx_reg_bank.sv
hdl/idx_addr_top.sv
verification/idx_addr_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the pass message in the output
verilator --binary --timing --top-module idx_addr_tb -f filelist.f -o idx_addr_sim \
    && ./obj_dir/idx_addr_sim | tee /dev/stderr | grep -q "test passed" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
